// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_dcache
FLIST     := flist.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: common/dcache_pkg.sv
// --------------------------------------------------
// shared geometry, address fields and types for the
// 4-way data cache. every RTL block takes what it
// needs through a wildcard import of this package.
// --------------------------------------------------

package dcache_pkg;

    // --------------------------------------------------
    // geometry
    // --------------------------------------------------
    localparam int unsigned NUM_WAYS       = 4;
    localparam int unsigned NUM_SETS       = 16;
    localparam int unsigned ADDR_W         = 32;
    localparam int unsigned WORD_W         = 64;
    localparam int unsigned LINE_W         = 128;
    localparam int unsigned WORDS_PER_LINE = LINE_W / WORD_W;
    localparam int unsigned BYTE_W         = 8;

    // address split: | tag | index | word sel | byte in word |
    localparam int unsigned OFFSET_W   = $clog2(LINE_W / BYTE_W);
    localparam int unsigned INDEX_W    = $clog2(NUM_SETS);
    localparam int unsigned TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int unsigned WORD_SEL_W = $clog2(WORDS_PER_LINE);
    localparam int unsigned WORD_OFF_W = OFFSET_W - WORD_SEL_W;

    // byte enables
    localparam int unsigned WORD_BE_W = WORD_W / BYTE_W;
    localparam int unsigned LINE_BE_W = LINE_W / BYTE_W;

    // width of the round-robin victim pointer
    localparam int unsigned WAY_IDX_W = $clog2(NUM_WAYS);

    // --------------------------------------------------
    // types
    // --------------------------------------------------
    typedef logic [NUM_WAYS-1:0] way_vec_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [WORD_W-1:0]   word_t;

    // a line is stored and moved as one vector, but selected and
    // merged word by word
    typedef union packed {
        logic [LINE_W-1:0]                vec;
        word_t [WORDS_PER_LINE-1:0]       words;
    } cache_line_t;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, COMPARE, REFILL, MEM_WRITE, RESPOND
    } ctrl_state_t;

    // --------------------------------------------------
    // address field helpers
    // --------------------------------------------------
    function automatic tag_t addr_tag(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W +: INDEX_W];
    endfunction

    function automatic logic [WORD_SEL_W-1:0] addr_word(input logic [ADDR_W-1:0] addr);
        return addr[WORD_OFF_W +: WORD_SEL_W];
    endfunction

endpackage

// File: common/way_if.sv
// --------------------------------------------------
// bundle between the cache controller, the ways and
// the way selector. the controller drives lookup and
// write, each way drives its own slice of the results
// --------------------------------------------------

`timescale 1ns/1ps

interface way_if import dcache_pkg::*; ();

    // lookup and write request from the controller
    index_t                 index;
    tag_t                   tag;
    logic                   rd_en;
    way_vec_t               wr_en;
    cache_line_t            wr_line;
    logic [LINE_BE_W-1:0]   wr_be;
    logic [WORD_SEL_W-1:0]  word_sel;

    // per-way results, one bit / one line per way
    way_vec_t                   hit_way;
    cache_line_t [NUM_WAYS-1:0] rd_line;

    // reduced result from the selector
    logic   hit;
    word_t  word;

    // controller also reads hit_way to pick the way for a store hit
    modport ctrl (
        output index, tag, rd_en, wr_en, wr_line, wr_be, word_sel,
        input  hit_way, hit, word
    );

    modport way (
        input  index, tag, rd_en, wr_en, wr_line, wr_be,
        output hit_way, rd_line
    );

    modport sel (
        input  hit_way, rd_line, word_sel,
        output hit, word
    );

endinterface

// File: dcache/cache_way.sv
// --------------------------------------------------
// one way of the cache: valid bits, tags and lines
// for every set. a lookup gives a registered hit bit
// and line one cycle after rd_en
// --------------------------------------------------

`timescale 1ns/1ps

module cache_way import dcache_pkg::*; #(
    parameter int unsigned WAY_ID = 0
) (
    input  logic   clk_i,
    input  logic   rst_ni,
    way_if.way     port
);

    logic [NUM_SETS-1:0]  valid_q;
    tag_t                 tag_mem  [NUM_SETS];
    cache_line_t          line_mem [NUM_SETS];

    // lookup result
    logic         hit_q;
    cache_line_t  rd_line_q;

    logic         wr_sel;

    // this way is written only when its own enable bit is set
    assign wr_sel = port.wr_en[WAY_ID];

    // --------------------------------------------------
    // valid bits and hit flag
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            hit_q   <= 1'b0;
        end else begin
            if (wr_sel) begin
                valid_q[port.index] <= 1'b1;
            end
            if (port.rd_en) begin
                hit_q <= valid_q[port.index] && (tag_mem[port.index] == port.tag);
            end
        end
    end

    // --------------------------------------------------
    // tag and line storage
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (wr_sel) begin
            tag_mem[port.index] <= port.tag;
            // byte-granular write, refill enables all bytes
            for (int unsigned b = 0; b < LINE_BE_W; b++) begin
                if (port.wr_be[b]) begin
                    line_mem[port.index].vec[b*BYTE_W +: BYTE_W] <=
                        port.wr_line.vec[b*BYTE_W +: BYTE_W];
                end
            end
        end
        if (port.rd_en) begin
            rd_line_q <= line_mem[port.index];
        end
    end

    // own slice of the shared result vectors
    assign port.hit_way[WAY_ID] = hit_q;
    assign port.rd_line[WAY_ID] = rd_line_q;

endmodule

// File: dcache/dcache_ctrl.sv
// --------------------------------------------------
// cache controller FSM. serves one core request at a
// time over a four-phase req/ack port, runs lookups,
// refills misses from memory, and writes every store
// through to memory with byte enables
// --------------------------------------------------

`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // core port
    input  logic                  req_i,
    input  logic                  we_i,
    input  logic [ADDR_W-1:0]     addr_i,
    input  word_t                 wdata_i,
    input  logic [WORD_BE_W-1:0]  be_i,
    output logic                  ack_o,
    output word_t                 rdata_o,
    // memory port
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output logic [ADDR_W-1:0]     mem_addr_o,
    output cache_line_t           mem_wdata_o,
    output logic [LINE_BE_W-1:0]  mem_be_o,
    input  logic                  mem_ack_i,
    input  cache_line_t           mem_rdata_i,
    // ways and selector
    way_if.ctrl                   ways
);

    ctrl_state_t state_q, state_d;

    // registered request
    logic                   we_q;
    tag_t                   tag_q;
    index_t                 index_q;
    logic [WORD_SEL_W-1:0]  wsel_q;
    word_t                  wdata_q;
    logic [WORD_BE_W-1:0]   be_q;

    // response and handshake state
    word_t                  rdata_q, rdata_d;
    logic                   rdata_load;
    logic                   ack_q, ack_d;
    logic                   mem_done_q, mem_done_d;
    logic [WAY_IDX_W-1:0]   victim_q, victim_d;

    // store data placed in its word of a line
    cache_line_t            store_line;
    logic [LINE_BE_W-1:0]   store_be;

    // --------------------------------------------------
    // store merge
    // --------------------------------------------------
    always_comb begin
        store_line = '0;
        store_line.words[wsel_q] = wdata_q;
        // word enables shifted into the addressed half of the line
        store_be = LINE_BE_W'(be_q) << (wsel_q * WORD_BE_W);
    end

    // lookup address always comes from the captured request
    assign ways.index    = index_q;
    assign ways.tag      = tag_q;
    assign ways.word_sel = wsel_q;

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_comb begin
        state_d      = state_q;
        ack_d        = ack_q;
        mem_done_d   = mem_done_q;
        victim_d     = victim_q;
        rdata_d      = ways.word;
        rdata_load   = 1'b0;
        ways.rd_en   = 1'b0;
        ways.wr_en   = '0;
        ways.wr_line = store_line;
        ways.wr_be   = store_be;

        unique case (state_q)
            IDLE: begin
                if (req_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                // ways register tag compare and line on this edge
                ways.rd_en = 1'b1;
                state_d    = COMPARE;
            end
            COMPARE: begin
                if (we_q) begin
                    // write-through, update the cached copy only on a hit
                    if (ways.hit) begin
                        ways.wr_en = ways.hit_way;
                    end
                    state_d = MEM_WRITE;
                end else if (ways.hit) begin
                    rdata_load = 1'b1;
                    state_d    = RESPOND;
                end else begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (!mem_done_q && mem_ack_i) begin
                    // install the full line in the victim way
                    ways.wr_en   = way_vec_t'(1) << victim_q;
                    ways.wr_line = mem_rdata_i;
                    ways.wr_be   = '1;
                    rdata_d      = mem_rdata_i.words[wsel_q];
                    rdata_load   = 1'b1;
                    victim_d     = victim_q + WAY_IDX_W'(1);
                    mem_done_d   = 1'b1;
                end else if (mem_done_q && !mem_ack_i) begin
                    mem_done_d = 1'b0;
                    state_d    = RESPOND;
                end
            end
            MEM_WRITE: begin
                if (!mem_done_q && mem_ack_i) begin
                    mem_done_d = 1'b1;
                end else if (mem_done_q && !mem_ack_i) begin
                    mem_done_d = 1'b0;
                    state_d    = RESPOND;
                end
            end
            RESPOND: begin
                // raise ack, then hold it until the core drops req
                if (!ack_q) begin
                    ack_d = 1'b1;
                end else if (!req_i) begin
                    ack_d   = 1'b0;
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // --------------------------------------------------
    // registers
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            ack_q      <= 1'b0;
            mem_done_q <= 1'b0;
            victim_q   <= '0;
        end else begin
            state_q    <= state_d;
            ack_q      <= ack_d;
            mem_done_q <= mem_done_d;
            victim_q   <= victim_d;
        end
    end

    // request and read data
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && req_i) begin
            we_q    <= we_i;
            tag_q   <= addr_tag(addr_i);
            index_q <= addr_index(addr_i);
            wsel_q  <= addr_word(addr_i);
            wdata_q <= wdata_i;
            be_q    <= be_i;
        end
        if (rdata_load) begin
            rdata_q <= rdata_d;
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign ack_o       = ack_q;
    assign rdata_o     = rdata_q;
    assign mem_req_o   = (state_q == REFILL || state_q == MEM_WRITE) && !mem_done_q;
    assign mem_we_o    = (state_q == MEM_WRITE);
    assign mem_addr_o  = {tag_q, index_q, {OFFSET_W{1'b0}}};
    assign mem_wdata_o = store_line;
    assign mem_be_o    = store_be;

    // memory request is held until the memory answers
    mem_req_hold_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_ack_i |=> mem_req_o
    ) else $error("mem_req_o dropped before mem_ack_i");

endmodule

// File: dcache/dcache_top.sv
// --------------------------------------------------
// data cache top level. plain core and memory ports,
// controller, four ways in a generate loop and the
// way selector, all joined by one way bundle
// --------------------------------------------------

`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // core port, four-phase req/ack
    input  logic                  req_i,
    input  logic                  we_i,
    input  logic [ADDR_W-1:0]     addr_i,
    input  word_t                 wdata_i,
    input  logic [WORD_BE_W-1:0]  be_i,
    output logic                  ack_o,
    output word_t                 rdata_o,
    // memory port, four-phase req/ack, line-aligned
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output logic [ADDR_W-1:0]     mem_addr_o,
    output cache_line_t           mem_wdata_o,
    output logic [LINE_BE_W-1:0]  mem_be_o,
    input  logic                  mem_ack_i,
    input  cache_line_t           mem_rdata_i
);

    way_if way_bus ();

    dcache_ctrl ctrl_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .be_i        (be_i),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_be_o    (mem_be_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .ways        (way_bus.ctrl)
    );

    // identical ways, each owns one slice of the result vectors
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way #(
            .WAY_ID (w)
        ) way_i (
            .clk_i  (clk_i),
            .rst_ni (rst_ni),
            .port   (way_bus.way)
        );
    end

    way_select sel_i (
        .port (way_bus.sel)
    );

endmodule

// File: dcache/way_select.sv
// --------------------------------------------------
// reduces the per-way lookup results to one hit flag
// and the addressed word of the hitting line. purely
// combinational
// --------------------------------------------------

`timescale 1ns/1ps

module way_select import dcache_pkg::*; (
    way_if.sel  port
);

    cache_line_t hit_line;

    // --------------------------------------------------
    // line mux
    // --------------------------------------------------
    // and-or mux, relies on the hit vector being one-hot or zero
    always_comb begin
        hit_line = '0;
        for (int unsigned w = 0; w < NUM_WAYS; w++) begin
            hit_line.vec = hit_line.vec | ({LINE_W{port.hit_way[w]}} & port.rd_line[w].vec);
        end
    end

    assign port.hit = |port.hit_way;

    // word picked from the line by the stored offset bit
    assign port.word = hit_line.words[port.word_sel];

    // a tag may live in only one way of a set, so more than one
    // hit means the refill installed a duplicate
    always_comb begin
        one_hit_a: assert final ($onehot0(port.hit_way))
            else $error("more than one way hit: %b", port.hit_way);
    end

endmodule

// File: dv/tb_clk_gen.sv
// --------------------------------------------------
// testbench clock and reset source. 4 ns clock, reset
// held low for the first three rising edges
// --------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        // release reset just after the third edge
        repeat (3) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

    always #2 clk_o = ~clk_o;

endmodule

// File: dv/tb_dcache.sv
// --------------------------------------------------
// directed testbench for the data cache top level.
// a behavioral memory answers the line port, each
// test task drives core accesses and checks results
// --------------------------------------------------

`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 4000;

    logic                  clk_i, rst_ni;
    logic                  req_i, we_i, ack_o;
    logic [ADDR_W-1:0]     addr_i;
    word_t                 wdata_i, rdata_o;
    logic [WORD_BE_W-1:0]  be_i;
    logic                  mem_req_o, mem_we_o, mem_ack_i;
    logic [ADDR_W-1:0]     mem_addr_o;
    cache_line_t           mem_wdata_o, mem_rdata_i;
    logic [LINE_BE_W-1:0]  mem_be_o;

    // memory model state
    cache_line_t  mem_lines [logic [ADDR_W-1:0]];
    int           mem_reads = 0;
    int           seed = 81924;
    int           cyc = 0;

    tb_clk_gen clk_gen_i (.clk_o(clk_i), .rst_no(rst_ni));

    dcache_top dut_i (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .req_i(req_i), .we_i(we_i), .addr_i(addr_i), .wdata_i(wdata_i), .be_i(be_i),
        .ack_o(ack_o), .rdata_o(rdata_o),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_be_o(mem_be_o),
        .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i)
    );

    // --------------------------------------------------
    // failure reporting and compare tasks
    // --------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("ERR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // run limit in clock cycles, about 30 accesses at the worst
    // memory delay and handshake with a wide margin
    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, the DUT did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    // --------------------------------------------------
    // memory contents and expected values
    // --------------------------------------------------
    // each word derived from its own byte address
    function automatic cache_line_t line_pattern(input logic [ADDR_W-1:0] line_addr);
        cache_line_t      line;
        logic [ADDR_W-1:0] wa;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            wa = line_addr + ADDR_W'(8 * i);
            line.words[i] = {wa ^ 32'h5eed_c0de, ~wa};
        end
        return line;
    endfunction

    function automatic cache_line_t mem_line_at(input logic [ADDR_W-1:0] line_addr);
        if (mem_lines.exists(line_addr)) begin
            return mem_lines[line_addr];
        end
        return line_pattern(line_addr);
    endfunction

    function automatic word_t pattern_word(input logic [ADDR_W-1:0] addr);
        cache_line_t line;
        line = line_pattern({addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
        return line.words[addr[3]];
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input logic [WORD_BE_W-1:0] be);
        word_t res;
        res = old_w;
        for (int b = 0; b < WORD_BE_W; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // memory responder, random delay before each ack
    initial begin
        int unsigned  delay;
        cache_line_t  line;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(posedge clk_i);
            #1;
            if (mem_req_o && !mem_ack_i) begin
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(posedge clk_i);
                #1;
                line = mem_line_at(mem_addr_o);
                if (mem_we_o) begin
                    for (int b = 0; b < LINE_BE_W; b++) begin
                        if (mem_be_o[b]) begin
                            line.vec[b*8 +: 8] = mem_wdata_o.vec[b*8 +: 8];
                        end
                    end
                    mem_lines[mem_addr_o] = line;
                end else begin
                    mem_reads++;
                    mem_rdata_i = line;
                end
                mem_ack_i = 1'b1;
                // hold ack until the DUT drops its request
                while (mem_req_o) begin
                    @(posedge clk_i);
                    #1;
                end
                mem_ack_i = 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // core side access
    // --------------------------------------------------
    // one four-phase access, latency counted from the sampling edge
    task automatic core_access(input logic we, input logic [ADDR_W-1:0] addr,
                               input word_t wdata, input logic [WORD_BE_W-1:0] be,
                               output word_t rdata, output int latency);
        int start;
        @(posedge clk_i);
        #1;
        req_i   = 1'b1;
        we_i    = we;
        addr_i  = addr;
        wdata_i = wdata;
        be_i    = be;
        start   = cyc;
        do begin
            @(posedge clk_i);
            #1;
        end while (!ack_o);
        latency = cyc - start - 1;
        rdata   = rdata_o;
        req_i   = 1'b0;
        do begin
            @(posedge clk_i);
            #1;
        end while (ack_o);
    endtask

    task automatic read_and_check(input logic [ADDR_W-1:0] addr, input word_t exp,
                                  input int exp_reads);
        word_t data;
        int    lat;
        int    reads0;
        reads0 = mem_reads;
        core_access(1'b0, addr, '0, '0, data, lat);
        check_word("rdata_o", data, exp);
        check_count("mem_reads", mem_reads, exp_reads);
        // a read expected not to touch memory is a hit
        if (exp_reads == reads0) begin
            check_count("hit latency", lat, 3);
        end
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input word_t data,
                              input logic [WORD_BE_W-1:0] be);
        word_t unused_data;
        int    lat;
        core_access(1'b1, addr, data, be, unused_data, lat);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    localparam logic [ADDR_W-1:0] ADDR_A = 32'h0000_1230;
    localparam logic [ADDR_W-1:0] ADDR_B = 32'h0004_5678;

    task automatic test_reset();
        check_bit("ack_o", ack_o, 1'b0);
        check_bit("mem_req_o", mem_req_o, 1'b0);
    endtask

    task automatic test_read_miss();
        read_and_check(ADDR_A, pattern_word(ADDR_A), mem_reads + 1);
    endtask

    task automatic test_read_hit();
        word_t data;
        int    lat;
        int    reads0;
        reads0 = mem_reads;
        core_access(1'b0, ADDR_A, '0, '0, data, lat);
        check_word("rdata_o", data, pattern_word(ADDR_A));
        check_count("hit latency", lat, 3);
        core_access(1'b0, ADDR_A + 8, '0, '0, data, lat);
        check_word("rdata_o", data, pattern_word(ADDR_A + 8));
        check_count("hit latency", lat, 3);
        check_count("mem_reads", mem_reads, reads0);
    endtask

    task automatic test_write_hit();
        word_t       exp;
        cache_line_t line;
        exp = merge_bytes(pattern_word(ADDR_A + 8), 64'h1122_3344_5566_7788, 8'h0f);
        write_word(ADDR_A + 8, 64'h1122_3344_5566_7788, 8'h0f);
        line = mem_line_at(ADDR_A & ~32'hf);
        check_word("memory word", line.words[1], exp);
        // the other word of the line keeps its old bytes
        check_word("memory word", line.words[0], pattern_word(ADDR_A));
        read_and_check(ADDR_A + 8, exp, mem_reads);
    endtask

    task automatic test_write_miss();
        word_t       exp;
        cache_line_t line;
        int          reads0;
        reads0 = mem_reads;
        exp = merge_bytes(pattern_word(ADDR_B), 64'hcafe_f00d_0bad_beef, 8'hf0);
        write_word(ADDR_B, 64'hcafe_f00d_0bad_beef, 8'hf0);
        line = mem_line_at(ADDR_B & ~32'hf);
        check_word("memory word", line.words[1], exp);
        check_word("memory word", line.words[0], pattern_word(ADDR_B & ~32'hf));
        check_count("mem_reads", mem_reads, reads0);
        // no allocate, so the read must refill
        read_and_check(ADDR_B, exp, reads0 + 1);
    endtask

    task automatic test_replacement();
        logic [ADDR_W-1:0] addrs [5];
        for (int k = 0; k < 5; k++) begin
            addrs[k] = 32'h0010_0090 + ADDR_W'(k) * 32'h0001_0000;
        end
        // five tags in set 9, the fifth install wraps onto the first
        for (int k = 0; k < 5; k++) begin
            read_and_check(addrs[k], pattern_word(addrs[k]), mem_reads + 1);
        end
        read_and_check(addrs[4], pattern_word(addrs[4]), mem_reads);
        read_and_check(addrs[0], pattern_word(addrs[0]), mem_reads + 1);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        req_i   = 1'b0;
        we_i    = 1'b0;
        addr_i  = '0;
        wdata_i = '0;
        be_i    = '0;
        @(posedge rst_ni);
        test_reset();
        test_read_miss();
        test_read_hit();
        test_write_hit();
        test_write_miss();
        test_replacement();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: flist.f
common/dcache_pkg.sv
common/way_if.sv
dcache/cache_way.sv
dcache/way_select.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
dv/tb_clk_gen.sv
dv/tb_dcache.sv
